// ==== rtl/stall_pkg.sv ====
package stall_pkg;

  // Number of hazard flags sampled at commit
  localparam int num_hazards = 8;

  // Hazard reasons plus the catch-all
  localparam int num_reasons = num_hazards + 1;

  // Stall reasons in priority order
  // Code of each hazard reason equals its flag index
  typedef enum logic [3:0] {
    ic_miss    = 4'd0,
    br_ovr     = 4'd1,
    fe_cmd     = 4'd2,
    mispredict = 4'd3,
    data_haz   = 4'd4,
    load_dep   = 4'd5,
    struct_haz = 4'd6,
    dc_miss    = 4'd7,
    // No flag set on a stalled cycle
    unknown    = 4'd8
  } stall_reason_e;

  // Named hazard flags
  // First member is the MSB, so listed from lowest priority down
  // ic_miss lands on bit 0
  typedef struct packed {
    logic dc_miss;
    logic struct_haz;
    logic load_dep;
    logic data_haz;
    logic mispredict;
    logic fe_cmd;
    logic br_ovr;
    logic ic_miss;
  } hazard_flags_s;

  // Same hazard word seen two ways
  // Named flags for packing, flat bits for the priority scan
  typedef union packed {
    hazard_flags_s          flags;
    logic [num_hazards-1:0] bits;
  } hazard_word_u;

endpackage

// ==== rtl/prof_cfg_pkg.sv ====
package prof_cfg_pkg;

  // Counter bank layout
  // Slot 0 counts enabled cycles
  localparam int idx_mcycle = 0;

  // Slot 1 counts retired instructions
  localparam int idx_minstret = 1;

  // Stall counters follow the two fixed slots
  // Counter for a reason lives at stall_offset + reason code
  localparam int stall_offset = 2;

  // Two fixed slots plus one per stall reason
  localparam int num_counters = stall_offset + stall_pkg::num_reasons;

  // Default sizing, overridden from the top level
  localparam int default_counter_width = 32;

  // Sv39 style virtual PC
  localparam int default_pc_width = 39;

endpackage

// ==== rtl/prof_if.sv ====
`timescale 1ns/10ps

// Sampler to classifier
// Registered copy of the raw commit inputs
interface sample_if
  import stall_pkg::*;
  import prof_cfg_pkg::*;
  #(parameter int pc_width_p = default_pc_width)
  ();

  logic                  en;
  logic                  freeze;
  // High once per retired instruction
  logic                  instret;
  logic [pc_width_p-1:0] pc;
  hazard_word_u          hazards;

  modport src (output en, output freeze, output instret, output pc, output hazards);
  modport dst (input en, input freeze, input instret, input pc, input hazards);

endinterface

// Classifier to counter bank and live outputs
interface class_if
  import stall_pkg::*;
  import prof_cfg_pkg::*;
  #(parameter int pc_width_p = default_pc_width)
  ();

  logic                  en;
  logic                  freeze;
  logic                  instret;
  // One reason per cycle, valid for counting only when instret is low
  stall_reason_e         reason;
  logic [pc_width_p-1:0] pc;
  // Registered inverse of freeze
  logic                  live;

  modport src (output en, output freeze, output instret, output reason, output pc,
               output live);
  modport dst (input en, input freeze, input instret, input reason, input pc, input live);

endinterface

// ==== rtl/commit_sampler.sv ====
`timescale 1ns/10ps

// Stage 1 of the profiler pipeline
// Flops the commit-stage signals once before any decoding
module commit_sampler
  import stall_pkg::*;
  #(parameter int pc_width_p = 39)
  (input  logic                  clk_i
   , input logic                  rst_i

   // Counting controls, plain levels
   , input logic                  en_i
   , input logic                  freeze_i

   // Retire strobe and committing PC
   , input logic                  instret_i
   , input logic [pc_width_p-1:0] pc_i

   // Raw hazard levels, packed by the top level
   , input hazard_word_u          hazards_i

   , sample_if.src                out
   );

  // Single register slice, no enable
  // Every field moves together so a cycle's sample stays aligned
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Inactive sample after reset
      out.en      <= 1'b0;
      out.freeze  <= 1'b0;
      out.instret <= 1'b0;
      out.pc      <= '0;
      out.hazards <= '0;
    end else begin
      out.en      <= en_i;
      out.freeze  <= freeze_i;
      out.instret <= instret_i;
      out.pc      <= pc_i;
      // Whole word copied, both views follow
      out.hazards <= hazards_i;
    end
  end

endmodule

// ==== rtl/stall_classifier.sv ====
`timescale 1ns/10ps

// Stage 2 of the profiler pipeline
// Reduces the hazard word to a single stall reason
module stall_classifier
  import stall_pkg::*;
  #(parameter int pc_width_p = 39)
  (input  logic  clk_i
   , input logic  rst_i

   , sample_if.dst in
   , class_if.src  out
   );

  // Reason picked this cycle, before the register
  stall_reason_e reason_n;

  // Fixed priority scan of the flat view
  // Lowest set index wins
  always_comb begin
    // Nothing flagged
    reason_n = unknown;
    // Walk from the top so the lowest hit is written last
    for (int i = num_hazards - 1; i >= 0; i--) begin
      if (in.hazards.bits[i]) begin
        // Flag index doubles as the reason code
        reason_n = stall_reason_e'(i);
      end
    end
  end

  // Classified sample register
  // Controls and PC ride along so the counter stage sees one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out.en      <= 1'b0;
      out.freeze  <= 1'b0;
      out.instret <= 1'b0;
      // Code zero after reset, qualified by live low
      out.reason  <= ic_miss;
      out.pc      <= '0;
      out.live    <= 1'b0;
    end else begin
      out.en      <= in.en;
      out.freeze  <= in.freeze;
      out.instret <= in.instret;
      out.reason  <= reason_n;
      out.pc      <= in.pc[pc_width_p-1:0];
      // Profile is live whenever this sample is not a freeze
      out.live    <= ~in.freeze;
    end
  end

endmodule

// ==== rtl/counter_bank.sv ====
`timescale 1ns/10ps

// Stage 3 of the profiler pipeline
// mcycle, minstret and one counter per stall reason
module counter_bank
  import prof_cfg_pkg::*;
  import stall_pkg::*;
  #(parameter int counter_width_p = 32)
  (input  logic  clk_i
   , input logic  rst_i

   , class_if.dst in

   , output logic [num_counters-1:0][counter_width_p-1:0] data_o
   );

  // Counter storage
  logic [num_counters-1:0][counter_width_p-1:0] cnt_r;

  // One increment strobe per counter
  logic [num_counters-1:0] inc;

  // Sample counts only when enabled and not a freeze
  logic count_en;

  assign count_en = in.en & ~in.freeze;

  // Decode this sample into increment strobes
  always_comb begin
    inc = '0;
    // Every counting cycle
    inc[idx_mcycle]   = count_en;
    // Retire cycles
    inc[idx_minstret] = count_en & in.instret;
    // Stalled cycles go to exactly one reason slot
    for (int r = 0; r < num_reasons; r++) begin
      inc[stall_offset + r] = count_en & ~in.instret & (in.reason == stall_reason_e'(r));
    end
  end

  always_ff @(posedge clk_i) begin
    // Freeze wipes the whole bank instead of counting
    if (rst_i || in.freeze) begin
      cnt_r <= '0;
    end else begin
      for (int i = 0; i < num_counters; i++) begin
        if (inc[i]) begin
          // Wraps at full width
          cnt_r[i] <= cnt_r[i] + counter_width_p'(1);
        end
      end
    end
  end

  assign data_o = cnt_r;

endmodule

// ==== rtl/commit_profiler.sv ====
`timescale 1ns/10ps

// Commit-stage profiler top level
// Three stage pipeline: sample, classify, count
module commit_profiler
  import prof_cfg_pkg::*;
  import stall_pkg::*;
  #(parameter int counter_width_p = default_counter_width
    , parameter int pc_width_p    = default_pc_width
    )
  (input  logic                  clk_i
   , input logic                  rst_i
   , input logic                  en_i
   , input logic                  freeze_i
   , input logic                  instret_i
   , input logic [pc_width_p-1:0] pc_i

   // Stall cause levels from the core
   , input logic                  ic_miss_i
   , input logic                  br_ovr_i
   , input logic                  fe_cmd_i
   , input logic                  mispredict_i
   , input logic                  data_haz_i
   , input logic                  load_dep_i
   , input logic                  struct_haz_i
   , input logic                  dc_miss_i

   // Counter bank, index layout from prof_cfg_pkg
   , output logic [num_counters-1:0][counter_width_p-1:0] data_o

   // Live view of the classified sample, 2 cycles behind the inputs
   , output logic                         v_o
   , output logic                         instret_o
   , output logic [$bits(stall_reason_e)-1:0] stall_o
   , output logic [pc_width_p-1:0]        pc_o
   );

  // Hazard levels gathered into one word
  hazard_word_u hazards_li;

  // Stage links
  sample_if #(.pc_width_p(pc_width_p)) sample_bus ();
  class_if  #(.pc_width_p(pc_width_p)) class_bus ();

  // Pack through the named view
  always_comb begin
    hazards_li.flags.ic_miss    = ic_miss_i;
    hazards_li.flags.br_ovr     = br_ovr_i;
    hazards_li.flags.fe_cmd     = fe_cmd_i;
    hazards_li.flags.mispredict = mispredict_i;
    hazards_li.flags.data_haz   = data_haz_i;
    hazards_li.flags.load_dep   = load_dep_i;
    hazards_li.flags.struct_haz = struct_haz_i;
    hazards_li.flags.dc_miss    = dc_miss_i;
  end

  // Edge N
  commit_sampler #(.pc_width_p(pc_width_p)) i_commit_sampler (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (en_i),
    .freeze_i  (freeze_i),
    .instret_i (instret_i),
    .pc_i      (pc_i),
    .hazards_i (hazards_li),
    .out       (sample_bus.src)
  );

  // Edge N+1
  stall_classifier #(.pc_width_p(pc_width_p)) i_stall_classifier (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .in    (sample_bus.dst),
    .out   (class_bus.src)
  );

  // Edge N+2
  counter_bank #(.counter_width_p(counter_width_p)) i_counter_bank (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .in     (class_bus.dst),
    .data_o (data_o)
  );

  // Live outputs straight off the classifier register
  assign v_o       = class_bus.live;
  assign instret_o = class_bus.instret;
  assign stall_o   = class_bus.reason;
  assign pc_o      = class_bus.pc;

endmodule

// ==== testbench/tb_commit_profiler.sv ====
`timescale 1ns/10ps

module tb_commit_profiler
  import prof_cfg_pkg::*;
  ();

  localparam int cw = 16;
  localparam int pw = default_pc_width;
  // Idle cycles that carry the last vector through the counter stage
  localparam int drain_cycles = 3;
  // Whole run bound in clock cycles
  localparam int run_limit = 200000;

  logic clk_i;
  logic rst_i;
  logic en_i;
  logic freeze_i;
  logic instret_i;
  logic [pw-1:0] pc_i;
  // Bit 0 ic_miss up to bit 7 dc_miss
  logic [7:0] haz;
  logic [num_counters-1:0][cw-1:0] data_o;
  logic v_o;
  logic instret_o;
  logic [3:0] stall_o;
  logic [pw-1:0] pc_o;

  // Expected live outputs in drive order
  logic q_chk[$];
  logic q_v[$];
  logic q_ir[$];
  logic [3:0] q_reason[$];
  logic [pw-1:0] q_pc[$];

  // Reference counter bank
  logic [cw-1:0] model [num_counters];

  string cur_name;
  int test_errs;
  int pass_cnt;
  int fail_cnt;

  commit_profiler #(.counter_width_p(cw), .pc_width_p(pw)) i_commit_profiler (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .en_i         (en_i),
    .freeze_i     (freeze_i),
    .instret_i    (instret_i),
    .pc_i         (pc_i),
    .ic_miss_i    (haz[0]),
    .br_ovr_i     (haz[1]),
    .fe_cmd_i     (haz[2]),
    .mispredict_i (haz[3]),
    .data_haz_i   (haz[4]),
    .load_dep_i   (haz[5]),
    .struct_haz_i (haz[6]),
    .dc_miss_i    (haz[7]),
    .data_o       (data_o),
    .v_o          (v_o),
    .instret_o    (instret_o),
    .stall_o      (stall_o),
    .pc_o         (pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run watchdog
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < run_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", run_limit);
    $display("Test FAILED");
    $finish;
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAILED %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
    test_errs++;
  endtask

  // First set flag from ic_miss upward gives the reason
  function automatic logic [3:0] priority_reason(input logic [7:0] hz);
    int i;
    i = 0;
    while (i < 8 && !hz[i]) i++;
    return 4'(i);
  endfunction

  task automatic update_model(input logic en, input logic fr, input logic ir,
                              input logic [3:0] reason);
    if (fr) begin
      // Freeze wipes everything whether enabled or not
      foreach (model[k]) model[k] = '0;
    end else if (en) begin
      model[idx_mcycle] = model[idx_mcycle] + cw'(1);
      if (ir) model[idx_minstret] = model[idx_minstret] + cw'(1);
      else model[stall_offset + int'(reason)] = model[stall_offset + int'(reason)] + cw'(1);
    end
  endtask

  // Compare live outputs with the vector from 2 falling edges back
  task automatic check_live();
    logic chk;
    logic ev;
    logic eir;
    logic [3:0] er;
    logic [pw-1:0] epc;
    if (q_chk.size() >= 2) begin
      chk = q_chk.pop_front();
      ev = q_v.pop_front();
      eir = q_ir.pop_front();
      er = q_reason.pop_front();
      epc = q_pc.pop_front();
      if (chk) begin
        if (v_o !== ev) report_mismatch("v_o", 64'(ev), 64'(v_o));
        if (instret_o !== eir) report_mismatch("instret_o", 64'(eir), 64'(instret_o));
        if (pc_o !== epc) report_mismatch("pc_o", 64'(epc), 64'(pc_o));
        // Reason only means something on a stalled cycle
        if (!eir && stall_o !== er) report_mismatch("stall_o", 64'(er), 64'(stall_o));
      end
    end
  endtask

  task automatic step(input logic en, input logic fr, input logic ir, input logic [7:0] hz,
                      input logic [pw-1:0] pc, input logic chk, input logic [3:0] reason);
    @(negedge clk_i);
    check_live();
    en_i = en;
    freeze_i = fr;
    instret_i = ir;
    haz = hz;
    pc_i = pc;
    q_chk.push_back(chk);
    q_v.push_back(~fr);
    q_ir.push_back(ir);
    q_reason.push_back(reason);
    q_pc.push_back(pc);
  endtask

  // Idle until the last vector has left the counter stage
  task automatic drain();
    for (int n = 0; n < drain_cycles; n++) begin
      step(1'b0, 1'b0, 1'b0, 8'h00, '0, 1'b0, 4'd8);
    end
  endtask

  task automatic finish_test();
    drain();
    // Whole bank against the reference after the drain
    for (int k = 0; k < num_counters; k++) begin
      if (data_o[k] !== model[k]) begin
        report_mismatch($sformatf("data_o[%0d]", k), 64'(model[k]), 64'(data_o[k]));
      end
    end
    if (test_errs == 0) pass_cnt++;
    else fail_cnt++;
    $display("done %0s: %0d errors", cur_name, test_errs);
    test_errs = 0;
  endtask

  initial begin
    int fd;
    int code;
    int rep;
    int en_v;
    int fr_v;
    int ir_v;
    int reason_v;
    int idx_v;
    int val_v;
    int unsigned seed;
    logic [7:0] kind_v;
    logic [8*24-1:0] name_v;
    logic [8*8-1:0] pc_tok;
    logic [7:0] hz_v;
    logic [pw-1:0] pc_v;
    logic [63:0] rnd;
    logic is_rand;
    string line;
    seed = $urandom(91105);
    rst_i = 1'b1;
    en_i = 1'b0;
    freeze_i = 1'b0;
    instret_i = 1'b0;
    pc_i = '0;
    haz = 8'h00;
    foreach (model[k]) model[k] = '0;
    test_errs = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cur_name = "reset";
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    // Reset state before any vector arrives
    if (v_o !== 1'b0) report_mismatch("v_o", 64'd0, 64'(v_o));
    if (instret_o !== 1'b0) report_mismatch("instret_o", 64'd0, 64'(instret_o));
    if (stall_o !== 4'd0) report_mismatch("stall_o", 64'd0, 64'(stall_o));
    for (int k = 0; k < num_counters; k++) begin
      if (data_o[k] !== '0) report_mismatch($sformatf("data_o[%0d]", k), 64'd0, 64'(data_o[k]));
    end
    fd = $fopen("testbench/testdata_profile.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/testdata_profile.txt");
      test_errs++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %s", kind_v, name_v);
          if ($sformatf("%0s", name_v) != cur_name) begin
            finish_test();
            cur_name = $sformatf("%0s", name_v);
          end
          if (kind_v == "V") begin
            code = $sscanf(line, "%s %s %d %d %d %d %b %h %d", kind_v, name_v, rep, en_v, fr_v,
                           ir_v, hz_v, pc_v, reason_v);
            // A pc token that is not hex stops the scan early
            is_rand = (code < 9);
            if (is_rand) begin
              code = $sscanf(line, "%s %s %d %d %d %d %b %s %d", kind_v, name_v, rep, en_v,
                             fr_v, ir_v, hz_v, pc_tok, reason_v);
            end
            if (priority_reason(hz_v) != 4'(reason_v)) begin
              $display("data file reason %0d in %0s breaks the priority order", reason_v,
                       cur_name);
              test_errs++;
            end
            for (int k = 0; k < rep; k++) begin
              if (is_rand) begin
                rnd = {$urandom, $urandom};
                pc_v = rnd[pw-1:0];
              end
              update_model(en_v != 0, fr_v != 0, ir_v != 0, priority_reason(hz_v));
              step(en_v != 0, fr_v != 0, ir_v != 0, hz_v, pc_v, 1'b1, 4'(reason_v));
            end
          end else begin
            code = $sscanf(line, "%s %s %d %d", kind_v, name_v, idx_v, val_v);
            drain();
            if (model[idx_v] !== val_v[cw-1:0]) begin
              $display("reference model gives %0d for counter %0d in %0s, data file says %0d",
                       model[idx_v], idx_v, cur_name, val_v);
              test_errs++;
            end
            if (data_o[idx_v] !== val_v[cw-1:0]) begin
              report_mismatch($sformatf("data_o[%0d]", idx_v), 64'(val_v[cw-1:0]),
                              64'(data_o[idx_v]));
            end
          end
        end
      end
      $fclose(fd);
    end
    finish_test();
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== commit_profiler.f ====
rtl/stall_pkg.sv
rtl/prof_cfg_pkg.sv
rtl/prof_if.sv
rtl/commit_sampler.sv
rtl/stall_classifier.sv
rtl/counter_bank.sv
rtl/commit_profiler.sv
testbench/tb_commit_profiler.sv

// ==== Makefile ====
# Verilator flow for the commit-stage profiler

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_commit_profiler
FILELIST   ?= commit_profiler.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run is judged by the fail message in the log
sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/testdata_profile.txt ====
# V name repeat en freeze instret hazards(bit7 dc_miss .. bit0 ic_miss) pc(hex)|random reason
# C name counter_index expected_value_after_drain
V prio_single 1 1 0 0 00000001 100 0
V prio_single 1 1 0 0 00000010 104 1
V prio_single 1 1 0 0 00000100 108 2
V prio_single 1 1 0 0 00001000 10c 3
V prio_single 1 1 0 0 00010000 110 4
V prio_single 1 1 0 0 00100000 114 5
V prio_single 1 1 0 0 01000000 118 6
V prio_single 1 1 0 0 10000000 11c 7
V prio_single 1 1 0 0 00000000 120 8
V prio_multi 1 1 0 0 11111111 random 0
V prio_multi 1 1 0 0 10010000 random 4
V prio_multi 1 1 0 0 11000100 random 2
V prio_multi 1 1 0 0 01101000 random 3
V prio_multi 1 1 0 0 10100000 random 5
C prio_multi 0 14
C prio_multi 2 2
C prio_multi 3 1
C prio_multi 10 1
V retire 3 1 0 1 00010000 random 4
V retire 1 1 0 1 00000000 200 8
C retire 0 18
C retire 1 4
C retire 6 2
V enable_off 4 0 0 0 00000100 random 2
V enable_off 2 0 0 1 00000000 random 8
C enable_off 0 18
C enable_off 4 2
V freeze 1 1 1 0 00000001 300 0
C freeze 0 0
C freeze 1 0
V freeze_resume 2 1 0 0 01000000 random 6
V freeze_resume 1 1 0 1 00000000 304 8
C freeze_resume 0 3
C freeze_resume 1 1
C freeze_resume 8 2
V wrap 1 1 1 0 00000000 0 8
V wrap 65538 1 0 0 00010000 400 4
C wrap 6 2
C wrap 0 2
